//--- Bender.yml
package:
  name: cmd_queue

sources:
  - include_dirs:
      - .
    files:
      - csr_pkg.sv
      - xfer_pkg.sv
      - queue_push_if.sv
      - dword_packer.sv
      - queue_fifo.sv
      - queue_ctrl.sv
      - credit_sender.sv
      - queue_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clkgen.sv
      - tb_queue_top.sv

//--- credit_sender.sv
// Credit based entry sender
`timescale 1ns/1ps
`include "queue_settings.svh"

module credit_sender
  import xfer_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         rvalid_i,
  output logic         rready_o,
  input  queue_entry_u rdata_i,
  input  logic         credit_return_i,
  output logic         tx_valid_o,
  output logic [7:0]   tx_opcode_o,
  output logic [7:0]   tx_tag_o,
  output logic [15:0]  tx_len_o,
  output logic [31:0]  tx_addr_o
);

  credit_t   credit_q;
  logic      pop;
  logic      tx_valid_q;
  cmd_desc_t desc_q;

  // Pop only with at least one credit in hand
  assign pop      = rvalid_i && (credit_q != '0);
  assign rready_o = pop;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q   <= credit_t'(`TX_CREDITS);
      tx_valid_q <= 1'b0;
    end else begin
      tx_valid_q <= pop;
      case ({credit_return_i, pop})
        2'b10:   credit_q <= credit_q + credit_t'(1);
        2'b01:   credit_q <= credit_q - credit_t'(1);
        default: credit_q <= credit_q;
      endcase
    end
  end

  // Descriptor view of the popped entry
  always_ff @(posedge clk_i) begin
    if (pop) begin
      desc_q <= rdata_i.desc;
    end
  end

  assign tx_valid_o  = tx_valid_q;
  assign tx_opcode_o = desc_q.opcode;
  assign tx_tag_o    = desc_q.tag;
  assign tx_len_o    = desc_q.len;
  assign tx_addr_o   = desc_q.addr;

  // Consumer must not return more credits than it was sent
  a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_q <= credit_t'(`TX_CREDITS));

endmodule

//--- csr_pkg.sv
// CSR side types
`include "queue_settings.svh"

package csr_pkg;

  // One dword written by software
  typedef logic [`CSR_W-1:0] csr_word_t;

  // Threshold code n selects 2^(n+1) entries
  // Code 0 keeps the trigger off
  typedef logic [`THLD_W-1:0] thld_code_t;

endpackage

//--- dword_packer.sv
// CSR dword packer
`timescale 1ns/1ps

module dword_packer
  import csr_pkg::*;
  import xfer_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         req_i,
  input  csr_word_t    data_i,
  output logic         ack_o,
  queue_push_if.packer push,
  input  logic         clr_i
);

  // High when the next dword is the upper half
  logic         half_q;
  logic         wvalid_q;
  logic         ack_q;
  queue_entry_u entry_q;
  logic         push_fire;

  assign push_fire = push.wvalid & push.wready;

  // Entry payload built one half at a time
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (half_q) begin
        entry_q.raw.hi <= data_i;
      end else begin
        entry_q.raw.lo <= data_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      half_q   <= 1'b0;
      wvalid_q <= 1'b0;
      ack_q    <= 1'b0;
    end else if (clr_i) begin
      half_q   <= 1'b0;
      wvalid_q <= 1'b0;
      // Release software still waiting on a dropped entry
      ack_q    <= wvalid_q;
    end else begin
      ack_q <= 1'b0;
      if (req_i) begin
        if (half_q) begin
          wvalid_q <= 1'b1;
        end else begin
          half_q <= 1'b1;
          ack_q  <= 1'b1;
        end
      end
      // High dword is acknowledged only once the FIFO takes it
      if (push_fire) begin
        wvalid_q <= 1'b0;
        half_q   <= 1'b0;
        ack_q    <= 1'b1;
      end
    end
  end

  assign push.wvalid = wvalid_q;
  assign push.wdata  = entry_q;
  assign ack_o       = ack_q;

  // Stalled entry must hold until the FIFO accepts it
  a_wdata_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push.wvalid && !push.wready && !clr_i |=> push.wvalid && $stable(push.wdata));

endmodule

//--- queue_ctrl.sv
// Queue status and thresholds
`timescale 1ns/1ps
`include "queue_settings.svh"

module queue_ctrl
  import csr_pkg::*;
  import xfer_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  depth_t     depth_i,
  input  thld_code_t start_thld_i,
  input  thld_code_t ready_thld_i,
  output thld_code_t ready_thld_o,
  output logic       start_thld_trig_o,
  output logic       ready_thld_trig_o,
  output logic       empty_o,
  input  logic       reg_rst_i,
  output logic       reg_rst_we_o,
  output logic       fifo_clr_o
);

  thld_code_t ready_clamped;
  depth_t     free_entries;
  // Soft reset seen but queue not yet drained
  logic       rst_pend_q;
  logic       rst_active;

  // Entry count selected by a threshold code
  function automatic logic [31:0] thld_entries(thld_code_t code);
    return 32'd1 << (32'(code) + 32'd1);
  endfunction

  // Codes that reach the full queue size clamp to the full-size code
  always_comb begin
    if (thld_entries(ready_thld_i) >= 32'(`QUEUE_DEPTH)) begin
      ready_clamped = thld_code_t'($clog2(`QUEUE_DEPTH) - 1);
    end else begin
      ready_clamped = ready_thld_i;
    end
  end

  assign free_entries = depth_t'(`QUEUE_DEPTH) - depth_i;
  assign empty_o      = (depth_i == '0);

  assign start_thld_trig_o = (start_thld_i != '0) &&
                             (32'(depth_i) >= thld_entries(start_thld_i));
  assign ready_thld_trig_o = (ready_thld_o != '0) &&
                             (32'(free_entries) >= thld_entries(ready_thld_o));

  assign rst_active = reg_rst_i | rst_pend_q;
  assign fifo_clr_o = rst_active;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ready_thld_o <= '0;
      rst_pend_q   <= 1'b0;
      reg_rst_we_o <= 1'b0;
    end else begin
      ready_thld_o <= ready_clamped;
      // Hold the clear until the FIFO reports empty, then acknowledge
      rst_pend_q   <= rst_active & ~empty_o;
      reg_rst_we_o <= rst_active & empty_o;
    end
  end

endmodule

//--- queue_fifo.sv
// Command entry FIFO
`timescale 1ns/1ps
`include "queue_settings.svh"

module queue_fifo
  import xfer_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  queue_push_if.fifo   push,
  input  logic         clr_i,
  output logic         rvalid_o,
  input  logic         rready_i,
  output queue_entry_u rdata_o,
  output logic         full_o
);

  queue_entry_u                     mem_q [`QUEUE_DEPTH];
  logic [$clog2(`QUEUE_DEPTH)-1:0] wptr_q;
  logic [$clog2(`QUEUE_DEPTH)-1:0] rptr_q;
  depth_t                           count_q;
  logic                             push_fire;
  logic                             pop_fire;

  assign full_o      = (count_q == depth_t'(`QUEUE_DEPTH));
  assign push.wready = ~full_o;
  assign push.depth  = count_q;
  assign rvalid_o    = (count_q != '0);
  assign rdata_o     = mem_q[rptr_q];

  assign push_fire = push.wvalid & push.wready;
  assign pop_fire  = rvalid_o & rready_i;

  always_ff @(posedge clk_i) begin
    if (push_fire) begin
      mem_q[wptr_q] <= push.wdata;
    end
  end

  // Pointers wrap naturally at a power-of-two depth
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else if (clr_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push_fire) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (pop_fire) begin
        rptr_q <= rptr_q + 1'b1;
      end
      case ({push_fire, pop_fire})
        2'b10:   count_q <= count_q + depth_t'(1);
        2'b01:   count_q <= count_q - depth_t'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  a_count_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= depth_t'(`QUEUE_DEPTH));

  // The reader must only request while entries are held
  a_no_empty_pop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rready_i |-> count_q != '0);

endmodule

//--- queue_push_if.sv
// Queue write port
`timescale 1ns/1ps

interface queue_push_if
  import xfer_pkg::*;
();

  logic         wvalid;
  logic         wready;
  queue_entry_u wdata;
  // Current occupancy also watched by the control block
  depth_t       depth;

  modport packer (
    output wvalid,
    output wdata,
    input  wready
  );

  modport fifo (
    input  wvalid,
    input  wdata,
    output wready,
    output depth
  );

endinterface

//--- queue_settings.svh
// Command queue sizes
`ifndef QUEUE_SETTINGS_SVH
`define QUEUE_SETTINGS_SVH

// Entries held by the queue
`define QUEUE_DEPTH 16
// Occupancy count width wide enough to hold QUEUE_DEPTH itself
`define DEPTH_W 5

// Software dword and packed entry widths
`define CSR_W 32
`define ENTRY_W 64

// Power-of-two threshold code width
`define THLD_W 3

// Credits granted after reset and also the ceiling
`define TX_CREDITS 4
`define CREDIT_W 3

`endif

//--- queue_top.sv
// Command queue top level
`timescale 1ns/1ps
`include "queue_settings.svh"

module queue_top
  import xfer_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  // CSR write side
  input  logic                req_i,
  input  logic [`CSR_W-1:0]   data_i,
  output logic                ack_o,
  // Thresholds
  input  logic [`THLD_W-1:0]  start_thld_i,
  input  logic [`THLD_W-1:0]  ready_thld_i,
  output logic [`THLD_W-1:0]  ready_thld_o,
  output logic                start_thld_trig_o,
  output logic                ready_thld_trig_o,
  // Status
  output logic                empty_o,
  output logic                full_o,
  output logic [`DEPTH_W-1:0] depth_o,
  // Soft reset
  input  logic                reg_rst_i,
  output logic                reg_rst_we_o,
  // Descriptor output
  output logic                tx_valid_o,
  output logic [7:0]          tx_opcode_o,
  output logic [7:0]          tx_tag_o,
  output logic [15:0]         tx_len_o,
  output logic [31:0]         tx_addr_o,
  input  logic                credit_return_i
);

  logic         fifo_clr;
  logic         fifo_rvalid;
  logic         fifo_rready;
  queue_entry_u fifo_rdata;

  queue_push_if u_push_if ();

  dword_packer u_packer (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (req_i),
    .data_i (data_i),
    .ack_o  (ack_o),
    .push   (u_push_if.packer),
    .clr_i  (fifo_clr)
  );

  queue_fifo u_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .push     (u_push_if.fifo),
    .clr_i    (fifo_clr),
    .rvalid_o (fifo_rvalid),
    .rready_i (fifo_rready),
    .rdata_o  (fifo_rdata),
    .full_o   (full_o)
  );

  queue_ctrl u_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .depth_i           (u_push_if.depth),
    .start_thld_i      (start_thld_i),
    .ready_thld_i      (ready_thld_i),
    .ready_thld_o      (ready_thld_o),
    .start_thld_trig_o (start_thld_trig_o),
    .ready_thld_trig_o (ready_thld_trig_o),
    .empty_o           (empty_o),
    .reg_rst_i         (reg_rst_i),
    .reg_rst_we_o      (reg_rst_we_o),
    .fifo_clr_o        (fifo_clr)
  );

  credit_sender u_sender (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .rvalid_i        (fifo_rvalid),
    .rready_o        (fifo_rready),
    .rdata_i         (fifo_rdata),
    .credit_return_i (credit_return_i),
    .tx_valid_o      (tx_valid_o),
    .tx_opcode_o     (tx_opcode_o),
    .tx_tag_o        (tx_tag_o),
    .tx_len_o        (tx_len_o),
    .tx_addr_o       (tx_addr_o)
  );

  assign depth_o = u_push_if.depth;

endmodule

//--- src.f
+incdir+.
csr_pkg.sv
xfer_pkg.sv
queue_push_if.sv
dword_packer.sv
queue_fifo.sv
queue_ctrl.sv
credit_sender.sv
queue_top.sv
tb_clkgen.sv
tb_queue_top.sv

//--- tb_clkgen.sv
// Testbench clock source
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk_o
);

  // 100 ns period
  initial begin
    clk_o = 1'b0;
  end

  always begin
    #50 clk_o = ~clk_o;
  end

endmodule

//--- tb_queue_top.sv
// Command queue testbench
`timescale 1ns/1ps
`include "queue_settings.svh"

module tb_queue_top
  import csr_pkg::*;
  import xfer_pkg::*;
();

  localparam int N_RANDOM = 24;
  // Pairs issued over all phases
  localparam int N_ENTRIES = N_RANDOM + 2 * `TX_CREDITS + `QUEUE_DEPTH + 1 + 3 + 2;
  localparam int CYCLE_LIMIT = 200 * N_ENTRIES + 2000;

  logic       clk;
  logic       rst_n;
  logic       req_i;
  csr_word_t  data_i;
  logic       ack_o;
  thld_code_t start_thld_i;
  thld_code_t ready_thld_i;
  thld_code_t ready_thld_o;
  logic       start_thld_trig_o;
  logic       ready_thld_trig_o;
  logic       empty_o;
  logic       full_o;
  depth_t     depth_o;
  logic       reg_rst_i;
  logic       reg_rst_we_o;
  logic       tx_valid_o;
  logic [7:0] tx_opcode_o;
  logic [7:0] tx_tag_o;
  logic [15:0] tx_len_o;
  logic [31:0] tx_addr_o;
  logic       credit_return_i = 1'b0;

  cmd_desc_t  exp_q [$];
  cmd_desc_t  got_desc;
  int         sent_cnt = 0;
  int         returned_cnt = 0;
  int         cycle_cnt = 0;
  bit         return_en = 1'b0;

  tb_clkgen u_clkgen (.clk_o(clk));

  queue_top u_queue_top (
    .clk_i(clk), .rst_ni(rst_n), .req_i(req_i), .data_i(data_i), .ack_o(ack_o),
    .start_thld_i(start_thld_i), .ready_thld_i(ready_thld_i), .ready_thld_o(ready_thld_o),
    .start_thld_trig_o(start_thld_trig_o), .ready_thld_trig_o(ready_thld_trig_o),
    .empty_o(empty_o), .full_o(full_o), .depth_o(depth_o),
    .reg_rst_i(reg_rst_i), .reg_rst_we_o(reg_rst_we_o),
    .tx_valid_o(tx_valid_o), .tx_opcode_o(tx_opcode_o), .tx_tag_o(tx_tag_o),
    .tx_len_o(tx_len_o), .tx_addr_o(tx_addr_o), .credit_return_i(credit_return_i)
  );

  // Reference packing with the low dword first and the opcode in the top byte
  function automatic queue_entry_u pack_entry(csr_word_t lo, csr_word_t hi);
    queue_entry_u e;
    e.desc.opcode = hi[31:24];
    e.desc.tag    = hi[23:16];
    e.desc.len    = hi[15:0];
    e.desc.addr   = lo;
    return e;
  endfunction

  function automatic logic start_trig_ref(int code, int depth);
    return (code != 0) && (depth >= (1 << (code + 1)));
  endfunction

  function automatic thld_code_t clamp_ready_ref(int code);
    if ((1 << (code + 1)) >= `QUEUE_DEPTH) begin
      return thld_code_t'($clog2(`QUEUE_DEPTH) - 1);
    end
    return thld_code_t'(code);
  endfunction

  function automatic logic ready_trig_ref(int code, int depth);
    return (code != 0) && ((`QUEUE_DEPTH - depth) >= (1 << (code + 1)));
  endfunction

  task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] exp);
    $display("ERROR: %s got 0x%0h expected 0x%0h", name, got, exp);
    $display("TEST FAILED");
    $fatal(1, "Mismatch on %s", name);
  endtask

  task automatic check_desc(string name, cmd_desc_t got, cmd_desc_t exp);
    if (got !== exp) report_mismatch(name, got, exp);
  endtask

  task automatic check_depth(string name, depth_t got, depth_t exp);
    if (got !== exp) report_mismatch(name, got, exp);
  endtask

  task automatic check_thld(string name, thld_code_t got, thld_code_t exp);
    if (got !== exp) report_mismatch(name, got, exp);
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) report_mismatch(name, got, exp);
  endtask

  // One CSR write
  // Low dwords must ack on the first cycle
  task automatic write_dword(csr_word_t data, bit quick_ack);
    @(posedge clk);
    req_i  <= 1'b1;
    data_i <= data;
    @(posedge clk);
    req_i  <= 1'b0;
    @(negedge clk);
    if (quick_ack) check_bit("ack_o", ack_o, 1'b1);
    while (!ack_o) @(negedge clk);
  endtask

  task automatic write_pair();
    csr_word_t    lo;
    csr_word_t    hi;
    queue_entry_u exp_entry;
    lo = $urandom;
    hi = $urandom;
    exp_entry = pack_entry(lo, hi);
    exp_q.push_back(exp_entry.desc);
    write_dword(lo, 1'b1);
    write_dword(hi, 1'b0);
  endtask

  // Wait for every expected entry, and optionally every credit back
  task automatic wait_drain(bit with_credits);
    while (exp_q.size() != 0) @(posedge clk);
    @(negedge clk);
    if (with_credits) begin
      while (sent_cnt != returned_cnt) @(negedge clk);
    end
  endtask

  // All threshold codes at the current, stable depth
  task automatic sweep_thresholds(int depth);
    for (int code = 0; code < 8; code++) begin
      @(posedge clk);
      start_thld_i <= thld_code_t'(code);
      ready_thld_i <= thld_code_t'(code);
      @(posedge clk);
      @(negedge clk);
      check_depth("depth_o", depth_o, depth_t'(depth));
      check_bit("start_thld_trig_o", start_thld_trig_o, start_trig_ref(code, depth));
      check_thld("ready_thld_o", ready_thld_o, clamp_ready_ref(code));
      check_bit("ready_thld_trig_o", ready_thld_trig_o,
                ready_trig_ref(int'(clamp_ready_ref(code)), depth));
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("TEST FAILED");
      $fatal(1, "Timeout after %0d cycles", cycle_cnt);
    end
  end

  // Consumer returns credits at random for entries it has received
  always @(posedge clk) begin
    if (return_en && (sent_cnt > returned_cnt) && ($urandom % 2 == 1)) begin
      credit_return_i <= 1'b1;
      returned_cnt    <= returned_cnt + 1;
    end else begin
      credit_return_i <= 1'b0;
    end
  end

  always @(negedge clk) begin
    if (rst_n && tx_valid_o) begin
      if (exp_q.size() == 0) begin
        $display("TEST FAILED");
        $fatal(1, "Descriptor sent with no entry expected");
      end else begin
        got_desc = {tx_opcode_o, tx_tag_o, tx_len_o, tx_addr_o};
        check_desc("tx descriptor", got_desc, exp_q.pop_front());
        sent_cnt = sent_cnt + 1;
      end
    end
  end

  initial begin
    csr_word_t    lo;
    csr_word_t    hi;
    queue_entry_u exp_entry;
    void'($urandom(19));
    rst_n        = 1'b0;
    req_i        = 1'b0;
    data_i       = '0;
    start_thld_i = '0;
    ready_thld_i = '0;
    reg_rst_i    = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_bit("ack_o", ack_o, 1'b0);
    check_bit("tx_valid_o", tx_valid_o, 1'b0);
    check_bit("reg_rst_we_o", reg_rst_we_o, 1'b0);
    check_thld("ready_thld_o", ready_thld_o, '0);
    check_bit("empty_o", empty_o, 1'b1);

    // Ordering and decode under random credit returns
    return_en = 1'b1;
    for (int i = 0; i < N_RANDOM; i++) write_pair();
    wait_drain(1'b1);
    return_en = 1'b0;

    // Credits run out, then the FIFO fills
    for (int i = 0; i < `TX_CREDITS; i++) write_pair();
    wait_drain(1'b0);
    sweep_thresholds(0);
    for (int i = 1; i <= `QUEUE_DEPTH; i++) begin
      write_pair();
      check_depth("depth_o", depth_o, depth_t'(i));
      check_bit("empty_o", empty_o, 1'b0);
      check_bit("full_o", full_o, (i == `QUEUE_DEPTH));
      sweep_thresholds(i);
    end

    // Back-pressure holds the high dword ack
    lo = $urandom;
    hi = $urandom;
    exp_entry = pack_entry(lo, hi);
    exp_q.push_back(exp_entry.desc);
    write_dword(lo, 1'b1);
    @(posedge clk);
    req_i  <= 1'b1;
    data_i <= hi;
    @(posedge clk);
    req_i  <= 1'b0;
    repeat (20) begin
      @(negedge clk);
      check_bit("ack_o", ack_o, 1'b0);
      check_bit("full_o", full_o, 1'b1);
    end
    return_en = 1'b1;
    while (!ack_o) @(negedge clk);
    wait_drain(1'b1);
    return_en = 1'b0;

    // Soft reset with entries queued and no credits
    for (int i = 0; i < `TX_CREDITS; i++) write_pair();
    wait_drain(1'b0);
    for (int i = 0; i < 3; i++) write_pair();
    check_depth("depth_o", depth_o, depth_t'(3));
    check_bit("empty_o", empty_o, 1'b0);
    @(posedge clk);
    reg_rst_i <= 1'b1;
    @(posedge clk);
    reg_rst_i <= 1'b0;
    exp_q.delete();
    @(negedge clk);
    while (!reg_rst_we_o) @(negedge clk);
    check_depth("depth_o", depth_o, '0);
    check_bit("empty_o", empty_o, 1'b1);
    @(negedge clk);
    check_bit("reg_rst_we_o", reg_rst_we_o, 1'b0);

    // Fresh entries only after the clear
    return_en = 1'b1;
    for (int i = 0; i < 2; i++) write_pair();
    wait_drain(1'b1);
    repeat (20) @(posedge clk);
    @(negedge clk);

    // Queue must be idle once everything is drained
    check_depth("depth_o", depth_o, '0);
    check_bit("empty_o", empty_o, 1'b1);
    check_bit("full_o", full_o, 1'b0);
    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- xfer_pkg.sv
// Hardware transfer types
`include "queue_settings.svh"

package xfer_pkg;

  // FIFO occupancy
  typedef logic [`DEPTH_W-1:0] depth_t;

  // Credits held by the sender
  typedef logic [`CREDIT_W-1:0] credit_t;

  // Command descriptor with the most significant field first
  typedef struct packed {
    logic [7:0]  opcode;
    logic [7:0]  tag;
    logic [15:0] len;
    logic [31:0] addr;
  } cmd_desc_t;

  // Queue entry
  // Raw halves are filled by the packer and desc is read by the sender
  typedef union packed {
    struct packed {
      logic [`CSR_W-1:0] hi;
      logic [`CSR_W-1:0] lo;
    } raw;
    cmd_desc_t desc;
  } queue_entry_u;

endpackage
